/* rv_defs.svh */
// Data width, register count and RV32I opcode and funct encodings
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN        32
`define RV_NREGS       32

// Major opcodes handled by the slice
`define RV_OP_OP       7'b0110011
`define RV_OP_IMM      7'b0010011
`define RV_OP_LUI      7'b0110111

// funct3 of OP and OP-IMM
`define RV_F3_ADD      3'b000
`define RV_F3_SLL      3'b001
`define RV_F3_SLT      3'b010
`define RV_F3_SLTU     3'b011
`define RV_F3_XOR      3'b100
`define RV_F3_SR       3'b101
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111

// funct7 where ALT selects SUB and SRA
`define RV_F7_BASE     7'b0000000
`define RV_F7_ALT      7'b0100000

`endif

/* rv_types_pkg.sv */
// ALU operation enum and the decode/execute pipeline structs
`include "rv_defs.svh"

package rv_types_pkg;

    // ========================================
    // ALU function select
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9,
        // Result is op2 unchanged for LUI
        alu_pass = 4'd10
    } alu_op_t;

    // ========================================
    // Decode to execute
    typedef struct packed {
        logic [`RV_XLEN-1:0] op1;
        logic [`RV_XLEN-1:0] op2;
        alu_op_t             alu_op;
        logic [4:0]          rd;
        logic                rd_write;
        logic                illegal;
        // Raw word kept for the retire port
        logic [31:0]         instr;
    } pipe_idex_t;

    // ========================================
    // Execute to writeback
    typedef struct packed {
        logic [`RV_XLEN-1:0] result;
        logic [4:0]          rd;
        logic                rd_write;
        logic                illegal;
        logic [31:0]         instr;
    } pipe_exwb_t;

endpackage

/* rv_alu.sv */
// Combinational RV32I integer ALU
`include "rv_defs.svh"

module rv_alu (
    input  logic [`RV_XLEN-1:0]   op1,
    input  logic [`RV_XLEN-1:0]   op2,
    input  rv_types_pkg::alu_op_t alu_op,
    output logic [`RV_XLEN-1:0]   result
);

    import rv_types_pkg::*;

    logic                do_sub;
    logic [`RV_XLEN-1:0] op2_add;
    logic [`RV_XLEN:0]   addsub;
    logic                lt_signed;
    logic                lt_unsigned;
    logic [4:0]          shamt;

    // ========================================
    // Shared adder for add, sub and compares
    assign do_sub  = alu_op == alu_sub || alu_op == alu_slt || alu_op == alu_sltu;
    assign op2_add = do_sub ? ~op2 : op2;
    assign addsub  = {1'b0, op1} + {1'b0, op2_add} + {{`RV_XLEN{1'b0}}, do_sub};

    // No carry out of op1 - op2 means a borrow
    assign lt_unsigned = !addsub[`RV_XLEN];
    // Differing signs settle it without the subtraction
    assign lt_signed   = (op1[`RV_XLEN-1] != op2[`RV_XLEN-1]) ?
                         op1[`RV_XLEN-1] : addsub[`RV_XLEN-1];

    assign shamt = op2[4:0];

    // ========================================
    // Result select
    always_comb begin
        case (alu_op)
            alu_add,
            alu_sub:  result = addsub[`RV_XLEN-1:0];
            alu_sll:  result = op1 << shamt;
            alu_slt:  result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            alu_xor:  result = op1 ^ op2;
            alu_srl:  result = op1 >> shamt;
            alu_sra:  result = $signed(op1) >>> shamt;
            alu_or:   result = op1 | op2;
            alu_and:  result = op1 & op2;
            alu_pass: result = op2;
            default:  result = '0;
        endcase
    end

endmodule

/* rv_execute.sv */
// Execute pipestage around the ALU
`include "rv_defs.svh"

module rv_execute (
    input  logic                     clk,
    input  logic                     rstz,
    input  rv_types_pkg::pipe_idex_t decode,
    input  logic                     pipe_in_vld,
    output logic                     pipe_in_rdy,
    output rv_types_pkg::pipe_exwb_t execute,
    output logic                     pipe_out_vld,
    input  logic                     pipe_out_rdy
);

    logic [`RV_XLEN-1:0] alu_result;

    // ========================================
    // ALU
    rv_alu u_alu (
        .op1    (decode.op1),
        .op2    (decode.op2),
        .alu_op (decode.alu_op),
        .result (alu_result)
    );

    // ========================================
    // Output register
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            pipe_out_vld <= 1'b0;
        end else if (pipe_in_vld && pipe_in_rdy) begin
            pipe_out_vld <= 1'b1;
        end else if (pipe_out_vld && pipe_out_rdy) begin
            pipe_out_vld <= 1'b0;
        end
    end

    // Result plus writeback controls
    always_ff @(posedge clk) begin
        if (pipe_in_vld && pipe_in_rdy) begin
            execute.result   <= alu_result;
            execute.rd       <= decode.rd;
            execute.rd_write <= decode.rd_write;
            execute.illegal  <= decode.illegal;
            execute.instr    <= decode.instr;
        end
    end

    // Empty or draining this cycle
    assign pipe_in_rdy = !pipe_out_vld || pipe_out_rdy;

    vld_held: assert property (@(posedge clk) disable iff (!rstz)
        pipe_out_vld && !pipe_out_rdy |=> pipe_out_vld)
        else $error("execute valid dropped without a handshake");

endmodule

/* rv_writeback.sv */
// Register file with zero register, retire port and write notify to decode
`include "rv_defs.svh"

module rv_writeback (
    input  logic                     clk,
    input  logic                     rstz,
    input  rv_types_pkg::pipe_exwb_t execute,
    input  logic                     execute_vld,
    output logic                     execute_rdy,
    input  logic [4:0]               rs1_addr,
    input  logic [4:0]               rs2_addr,
    output logic [`RV_XLEN-1:0]      rs1_data,
    output logic [`RV_XLEN-1:0]      rs2_data,
    output logic                     wb_en,
    output logic [4:0]               wb_rd,
    output logic                     retire_vld,
    input  logic                     retire_rdy,
    output logic [31:0]              retire_instr,
    output logic [4:0]               retire_rd,
    output logic [`RV_XLEN-1:0]      retire_data,
    output logic                     retire_write,
    output logic                     retire_illegal
);

    // Storage for x1..x31 only
    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

    // ========================================
    // Retire port
    assign retire_vld     = execute_vld;
    assign retire_instr   = execute.instr;
    assign retire_rd      = execute.rd;
    assign retire_data    = execute.result;
    assign retire_illegal = execute.illegal;
    // Writes to x0 and illegal words are dropped here
    assign retire_write   = execute.rd_write && execute.rd != 5'd0 && !execute.illegal;

    assign execute_rdy = retire_rdy;

    // Notify decode in the cycle the write lands
    assign wb_en = execute_vld && retire_rdy && retire_write;
    assign wb_rd = execute.rd;

    // ========================================
    // Register file
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= execute.result;
        end
    end

    // Read ports with x0 reading zero
    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        if (rs1_addr != 5'd0) begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr != 5'd0) begin
            rs2_data = regs[rs2_addr];
        end
    end

    no_x0_write: assert property (@(posedge clk) disable iff (!rstz)
        !(wb_en && wb_rd == 5'd0))
        else $error("register write to x0");

endmodule

/* rv_decode.sv */
// Instruction decoder with register read, pending-write scoreboard
// and registered valid/ready output stage
`include "rv_defs.svh"

module rv_decode (
    input  logic                     clk,
    input  logic                     rstz,
    input  logic [31:0]              instr,
    input  logic                     instr_vld,
    output logic                     instr_rdy,
    output logic [4:0]               rs1_addr,
    output logic [4:0]               rs2_addr,
    input  logic [`RV_XLEN-1:0]      rs1_data,
    input  logic [`RV_XLEN-1:0]      rs2_data,
    input  logic                     wb_en,
    input  logic [4:0]               wb_rd,
    output rv_types_pkg::pipe_idex_t decode,
    output logic                     decode_vld,
    input  logic                     decode_rdy
);

    import rv_types_pkg::*;

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [4:0]             rd;
    logic                   use_rs1;
    logic                   use_rs2;
    logic                   hazard;
    logic                   accept;
    logic [`RV_NREGS-1:0]   pending;
    pipe_idex_t             dec_next;

    // Shared funct3 mapping for OP and OP-IMM
    function automatic alu_op_t f3_to_op(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            `RV_F3_ADD:  op = alt ? alu_sub : alu_add;
            `RV_F3_SLL:  op = alu_sll;
            `RV_F3_SLT:  op = alu_slt;
            `RV_F3_SLTU: op = alu_sltu;
            `RV_F3_XOR:  op = alu_xor;
            `RV_F3_SR:   op = alt ? alu_sra : alu_srl;
            `RV_F3_OR:   op = alu_or;
            default:     op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // ========================================
    // Field decode
    always_comb begin
        dec_next          = '0;
        dec_next.instr    = instr;
        dec_next.rd       = rd;
        dec_next.op1      = rs1_data;
        dec_next.op2      = rs2_data;
        dec_next.alu_op   = alu_add;
        use_rs1           = 1'b0;
        use_rs2           = 1'b0;
        case (opcode)
            `RV_OP_OP: begin
                use_rs1           = 1'b1;
                use_rs2           = 1'b1;
                dec_next.rd_write = 1'b1;
                dec_next.alu_op   = f3_to_op(funct3, instr[30]);
                // ALT only exists for SUB and SRA
                dec_next.illegal  = !(funct7 == `RV_F7_BASE ||
                    (funct7 == `RV_F7_ALT &&
                    (funct3 == `RV_F3_ADD || funct3 == `RV_F3_SR)));
            end
            `RV_OP_IMM: begin
                use_rs1           = 1'b1;
                dec_next.rd_write = 1'b1;
                dec_next.op2      = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
                // Bit 30 is immediate data except for right shifts
                dec_next.alu_op   = f3_to_op(funct3, funct3 == `RV_F3_SR && instr[30]);
                if (funct3 == `RV_F3_SLL) begin
                    dec_next.illegal = funct7 != `RV_F7_BASE;
                end else if (funct3 == `RV_F3_SR) begin
                    dec_next.illegal = funct7 != `RV_F7_BASE && funct7 != `RV_F7_ALT;
                end
            end
            `RV_OP_LUI: begin
                dec_next.rd_write = 1'b1;
                dec_next.op1      = '0;
                dec_next.op2      = {instr[31:12], 12'b0};
                dec_next.alu_op   = alu_pass;
            end
            default: begin
                dec_next.illegal  = 1'b1;
            end
        endcase
        if (dec_next.illegal) begin
            dec_next.rd_write = 1'b0;
        end
    end

    // ========================================
    // Scoreboard
    // A pending rd also stalls so a later write never gets its bit cleared early
    assign hazard = (use_rs1 && pending[rs1_addr]) ||
                    (use_rs2 && pending[rs2_addr]) ||
                    (dec_next.rd_write && pending[rd]);

    assign instr_rdy = !hazard && (!decode_vld || decode_rdy);
    assign accept    = instr_vld && instr_rdy;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            pending <= '0;
        end else begin
            if (wb_en) begin
                pending[wb_rd] <= 1'b0;
            end
            // Set wins over a clear in the same cycle
            if (accept && dec_next.rd_write && rd != 5'd0) begin
                pending[rd] <= 1'b1;
            end
        end
    end

    // ========================================
    // Output stage
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            decode_vld <= 1'b0;
        end else if (accept) begin
            decode_vld <= 1'b1;
        end else if (decode_vld && decode_rdy) begin
            decode_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            decode <= dec_next;
        end
    end

    hold_stable: assert property (@(posedge clk) disable iff (!rstz)
        decode_vld && !decode_rdy |=> $stable(decode))
        else $error("decode payload changed while stalled");

    x0_never_pending: assert property (@(posedge clk) disable iff (!rstz)
        !pending[0])
        else $error("pending bit set for x0");

endmodule

/* rv_alu_core.sv */
// Top level of the execution slice, decode to execute to writeback
`include "rv_defs.svh"

module rv_alu_core (
    input  logic                clk,
    input  logic                rstz,
    input  logic [31:0]         instr,
    input  logic                instr_vld,
    output logic                instr_rdy,
    output logic                retire_vld,
    input  logic                retire_rdy,
    output logic [31:0]         retire_instr,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data,
    output logic                retire_write,
    output logic                retire_illegal
);

    import rv_types_pkg::*;

    pipe_idex_t          decode;
    logic                decode_vld;
    logic                decode_rdy;
    pipe_exwb_t          execute;
    logic                execute_vld;
    logic                execute_rdy;
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic                wb_en;
    logic [4:0]          wb_rd;

    rv_decode u_decode (
        .clk        (clk),
        .rstz       (rstz),
        .instr      (instr),
        .instr_vld  (instr_vld),
        .instr_rdy  (instr_rdy),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .decode     (decode),
        .decode_vld (decode_vld),
        .decode_rdy (decode_rdy)
    );

    rv_execute u_execute (
        .clk          (clk),
        .rstz         (rstz),
        .decode       (decode),
        .pipe_in_vld  (decode_vld),
        .pipe_in_rdy  (decode_rdy),
        .execute      (execute),
        .pipe_out_vld (execute_vld),
        .pipe_out_rdy (execute_rdy)
    );

    rv_writeback u_writeback (
        .clk            (clk),
        .rstz           (rstz),
        .execute        (execute),
        .execute_vld    (execute_vld),
        .execute_rdy    (execute_rdy),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .wb_en          (wb_en),
        .wb_rd          (wb_rd),
        .retire_vld     (retire_vld),
        .retire_rdy     (retire_rdy),
        .retire_instr   (retire_instr),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_write   (retire_write),
        .retire_illegal (retire_illegal)
    );

endmodule

/* tb_rv_alu_core.sv */
// Testbench for the ALU execution slice with stimulus, reference register
// model, concurrent retire checks and per-test reporting
`include "rv_defs.svh"

module tb_rv_alu_core;

    typedef struct packed {
        logic [31:0] data;
        logic        write;
        logic        illegal;
    } ref_res_t;

    // Sum of the instruction counts of all six tests
    localparam int total_instr = 92;

    logic        clk;
    logic        rstz;
    logic [31:0] instr;
    logic        instr_vld;
    logic        instr_rdy;
    logic        retire_vld;
    logic        retire_rdy;
    logic [31:0] retire_instr;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        retire_write;
    logic        retire_illegal;

    int          seed;
    int          fail_cnt;
    int          fail_mark;
    int          retired_cnt;
    int          retired_mark;
    int          in_flight;
    int          hold_low;
    logic        bp_phase;
    logic        took;
    logic        rt_fire;
    logic        acc_fire;
    logic [31:0] acc_word;

    logic [31:0] sent_q[$];
    logic [31:0] model_regs [0:31];
    logic        exp_valid;
    logic [31:0] exp_instr;
    ref_res_t    exp_res;

    rv_alu_core rv_alu_core_i (
        .clk            (clk),
        .rstz           (rstz),
        .instr          (instr),
        .instr_vld      (instr_vld),
        .instr_rdy      (instr_rdy),
        .retire_vld     (retire_vld),
        .retire_rdy     (retire_rdy),
        .retire_instr   (retire_instr),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_write   (retire_write),
        .retire_illegal (retire_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================
    // Instruction encoders
    function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
    endfunction

    function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `RV_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `RV_OP_LUI};
    endfunction

    // ========================================
    // Reference model of the RV32I rules
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'b0, $signed(a) < $signed(b)};
            3'd3: r = {31'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic ref_res_t model_exec(input logic [31:0] w);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm;
        ref_res_t    r;
        f3  = w[14:12];
        f7  = w[31:25];
        imm = {{20{w[31]}}, w[31:20]};
        r   = '0;
        case (w[6:0])
            `RV_OP_OP: begin
                r.illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                r.data    = alu_ref(f3, f7[5], model_regs[w[19:15]], model_regs[w[24:20]]);
            end
            `RV_OP_IMM: begin
                if (f3 == 3'd1) begin
                    r.illegal = f7 != 7'h00;
                end else if (f3 == 3'd5) begin
                    r.illegal = f7 != 7'h00 && f7 != 7'h20;
                end
                r.data = alu_ref(f3, f3 == 3'd5 && f7[5], model_regs[w[19:15]], imm);
            end
            `RV_OP_LUI: r.data = {w[31:12], 12'b0};
            default:    r.illegal = 1'b1;
        endcase
        r.write = !r.illegal && w[11:7] != 5'd0;
        return r;
    endfunction

    // Handshakes latched at the falling edge where the pins are settled
    always @(negedge clk) begin
        rt_fire  = rstz && retire_vld && retire_rdy;
        acc_fire = rstz && instr_vld && instr_rdy;
        acc_word = instr;
    end

    always @(posedge clk) begin : model_update
        ref_res_t res;
        if (!rstz) begin
            sent_q.delete();
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            in_flight = 0;
            exp_valid = 1'b0;
        end else begin
            if (rt_fire && sent_q.size() != 0) begin
                res = model_exec(sent_q[0]);
                if (res.write) begin
                    model_regs[sent_q[0][11:7]] = res.data;
                end
                void'(sent_q.pop_front());
                retired_cnt++;
            end
            if (acc_fire) begin
                sent_q.push_back(acc_word);
            end
            in_flight = sent_q.size();
            exp_valid = in_flight != 0;
            if (exp_valid) begin
                exp_instr = sent_q[0];
                exp_res   = model_exec(sent_q[0]);
            end
        end
    end

    // ========================================
    // Retire checks
    order_ok: assert property (@(posedge clk) disable iff (!rstz)
        retire_vld && retire_rdy |-> exp_valid)
        else begin
            $display("Instruction retired with nothing outstanding (duplicate)");
            fail_cnt++;
        end

    instr_ok: assert property (@(posedge clk) disable iff (!rstz)
        retire_vld && retire_rdy |-> retire_instr == exp_instr)
        else begin
            $display("[FAIL] retire_instr: got %h, expected %h",
                     $sampled(retire_instr), $sampled(exp_instr));
            fail_cnt++;
        end

    rd_ok: assert property (@(posedge clk) disable iff (!rstz)
        retire_vld && retire_rdy |-> retire_rd == exp_instr[11:7])
        else begin
            $display("[FAIL] retire_rd: got %h, expected %h",
                     $sampled(retire_rd), $sampled(exp_instr[11:7]));
            fail_cnt++;
        end

    data_ok: assert property (@(posedge clk) disable iff (!rstz)
        retire_vld && retire_rdy && !exp_res.illegal |-> retire_data == exp_res.data)
        else begin
            $display("[FAIL] retire_data: got %h, expected %h",
                     $sampled(retire_data), $sampled(exp_res.data));
            fail_cnt++;
        end

    write_ok: assert property (@(posedge clk) disable iff (!rstz)
        retire_vld && retire_rdy |-> retire_write == exp_res.write)
        else begin
            $display("[FAIL] retire_write: got %h, expected %h",
                     $sampled(retire_write), $sampled(exp_res.write));
            fail_cnt++;
        end

    illegal_ok: assert property (@(posedge clk) disable iff (!rstz)
        retire_vld && retire_rdy |-> retire_illegal == exp_res.illegal)
        else begin
            $display("[FAIL] retire_illegal: got %h, expected %h",
                     $sampled(retire_illegal), $sampled(exp_res.illegal));
            fail_cnt++;
        end

    // Two cycles from acceptance to retire when nothing pushes back
    latency_ok: assert property (@(posedge clk) disable iff (!rstz)
        instr_vld && instr_rdy && !bp_phase |->
        ##2 (retire_vld && retire_instr == $past(instr, 2)))
        else begin
            $display("Accepted instruction did not retire two cycles later");
            fail_cnt++;
        end

    payload_held: assert property (@(posedge clk) disable iff (!rstz)
        retire_vld && !retire_rdy |=> retire_vld && $stable(retire_instr) &&
        $stable(retire_data) && $stable(retire_rd) && $stable(retire_write) &&
        $stable(retire_illegal))
        else begin
            $display("Retire payload changed or valid dropped while stalled");
            fail_cnt++;
        end

    full_stalls: assert property (@(posedge clk) disable iff (!rstz)
        retire_vld && !retire_rdy && in_flight == 2 |-> !instr_rdy)
        else begin
            $display("Decode accepted input while the pipe was full");
            fail_cnt++;
        end

    depth_ok: assert property (@(posedge clk) disable iff (!rstz)
        in_flight <= 2)
        else begin
            $display("More than two instructions in flight");
            fail_cnt++;
        end

    reset_clears: assert property (@(posedge clk) $rose(rstz) |-> !retire_vld)
        else begin
            $display("Retire valid high right after reset");
            fail_cnt++;
        end

    // ========================================
    // Stimulus tasks
    task automatic step_cycle();
        logic [31:0] rnd;
        @(negedge clk);
        took = instr_vld && instr_rdy;
        @(posedge clk);
        #1;
        if (bp_phase) begin
            rnd        = $random(seed);
            retire_rdy = (hold_low != 0) ? 1'b0 : rnd[0];
            if (hold_low != 0) begin
                hold_low = hold_low - 1;
            end
        end
    endtask

    task automatic send_instr(input logic [31:0] w);
        instr     = w;
        instr_vld = 1'b1;
        do begin
            step_cycle();
        end while (!took);
        instr_vld = 1'b0;
    endtask

    task automatic drain_pipe();
        while (in_flight != 0) begin
            step_cycle();
        end
    endtask

    task automatic apply_reset();
        rstz       = 1'b0;
        retire_rdy = 1'b1;
        bp_phase   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rstz = 1'b1;
    endtask

    task automatic report_test(input string name);
        $display("test %-12s retired %0d, errors %0d", name,
                 retired_cnt - retired_mark, fail_cnt - fail_mark);
        retired_mark = retired_cnt;
        fail_mark    = fail_cnt;
    endtask

    // ========================================
    // Test sequence
    initial begin
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic [11:0] imm;
        seed         = 32'hded8;
        fail_cnt     = 0;
        fail_mark    = 0;
        retired_cnt  = 0;
        retired_mark = 0;
        hold_low     = 0;
        instr        = '0;
        instr_vld    = 1'b0;
        apply_reset();

        // Operand setup followed by every OP and OP-IMM function
        send_instr(lui_word(20'h80000, 5'd1));
        send_instr(imm_word(12'h123, 5'd1, 3'd0, 5'd1));
        send_instr(lui_word(20'h12345, 5'd2));
        send_instr(imm_word(12'hfff, 5'd2, 3'd0, 5'd2));
        send_instr(imm_word(12'd7, 5'd0, 3'd0, 5'd3));
        send_instr(imm_word(12'hffb, 5'd0, 3'd0, 5'd4));
        for (int f = 0; f < 8; f++) begin
            send_instr(op_word(7'h00, 5'd4, 5'd1, 3'(f), 5'(10 + f)));
        end
        send_instr(op_word(7'h20, 5'd4, 5'd1, 3'd0, 5'd18));
        send_instr(op_word(7'h20, 5'd3, 5'd1, 3'd5, 5'd19));
        for (int f = 0; f < 8; f++) begin
            imm = (f == 1 || f == 5) ? 12'd9 : 12'h8a5;
            send_instr(imm_word(imm, 5'd2, 3'(f), 5'(20 + f)));
        end
        send_instr(imm_word({7'h20, 5'd3}, 5'd1, 3'd5, 5'd28));
        drain_pipe();
        report_test("arith");

        send_instr(imm_word(12'd5, 5'd1, 3'd0, 5'd0));
        send_instr(op_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        send_instr(lui_word(20'habcde, 5'd0));
        send_instr(op_word(7'h00, 5'd2, 5'd0, 3'd0, 5'd5));
        send_instr(imm_word(12'd0, 5'd0, 3'd0, 5'd6));
        drain_pipe();
        report_test("x0");

        // Dependent chain first and independent words after
        repeat (4) send_instr(imm_word(12'd1, 5'd7, 3'd0, 5'd7));
        send_instr(op_word(7'h00, 5'd7, 5'd7, 3'd0, 5'd8));
        send_instr(op_word(7'h20, 5'd7, 5'd8, 3'd0, 5'd9));
        for (int r = 11; r < 15; r++) begin
            send_instr(imm_word(12'(r * 3), 5'd0, 3'd0, 5'(r)));
        end
        drain_pipe();
        report_test("hazard");

        send_instr(op_word(7'h01, 5'd2, 5'd1, 3'd0, 5'd10));
        send_instr(op_word(7'h00, 5'd0, 5'd10, 3'd0, 5'd15));
        send_instr(imm_word({7'h20, 5'd3}, 5'd1, 3'd1, 5'd11));
        send_instr(op_word(7'h00, 5'd0, 5'd11, 3'd0, 5'd16));
        send_instr(32'h0000_2083);
        send_instr(32'h0040_006f);
        send_instr(32'hffff_ffff);
        drain_pipe();
        report_test("illegal");

        // Forced stall at the start fills both stages
        bp_phase = 1'b1;
        hold_low = 6;
        for (int n = 0; n < 40; n++) begin
            rnd = $random(seed);
            f3  = rnd[14:12];
            if (rnd[0]) begin
                send_instr(op_word((rnd[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                                   rnd[24:20], rnd[19:15], f3, rnd[11:7]));
            end else begin
                if (f3 == 3'd1) begin
                    imm = {7'h00, rnd[24:20]};
                end else if (f3 == 3'd5) begin
                    imm = {1'b0, rnd[30], 5'b0, rnd[24:20]};
                end else begin
                    imm = rnd[31:20];
                end
                send_instr(imm_word(imm, rnd[19:15], f3, rnd[11:7]));
            end
        end
        drain_pipe();
        bp_phase   = 1'b0;
        retire_rdy = 1'b1;
        report_test("backpressure");

        // Reset lands with two words still in the pipe
        bp_phase = 1'b1;
        hold_low = 2;
        send_instr(imm_word(12'd11, 5'd0, 3'd0, 5'd1));
        send_instr(imm_word(12'd22, 5'd0, 3'd0, 5'd2));
        apply_reset();
        send_instr(op_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd5));
        send_instr(op_word(7'h20, 5'd7, 5'd31, 3'd0, 5'd6));
        send_instr(imm_word(12'd0, 5'd9, 3'd0, 5'd8));
        drain_pipe();
        report_test("reset");

        $display("tests 6, retired %0d, errors %0d", retired_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (total_instr * 20) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", total_instr * 20);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
rv_types_pkg.sv
rv_alu.sv
rv_execute.sv
rv_writeback.sv
rv_decode.sv
rv_alu_core.sv
tb_rv_alu_core.sv
